/* stq.f */
+incdir+hw
hw/stq_pkg.sv
hw/stq_ring.sv
hw/stq_addr_cam.sv
hw/stq_data_array.sv
hw/stq_drain.sv
hw/stq_top.sv
verif/stq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the store queue testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module stq_tb -f stq.f -o stq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/stq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0

/* verif/stq_tb.sv */
`timescale 1ns/100ps

`include "stq_consts.svh"

module stq_tb;

  logic               clk;
  logic               arst_n;
  logic               alloc;
  logic               wrt0_en;
  stq_pkg::stq_idx_t  wrt0_idx;
  stq_pkg::stq_addr_t wrt0_addr;
  logic               wrt1_en;
  stq_pkg::stq_idx_t  wrt1_idx;
  stq_pkg::stq_word_t wrt1_data;
  logic               chk0_en;
  stq_pkg::stq_addr_t chk0_addr;
  stq_pkg::stq_idx_t  chk0_age;
  logic               chk1_en;
  stq_pkg::stq_addr_t chk1_addr;
  stq_pkg::stq_idx_t  chk1_age;
  logic               commit;
  stq_pkg::stq_idx_t  alloc_idx;
  logic               full;
  logic               empty;
  logic               chk0_valid;
  logic               chk0_hit;
  logic               chk0_wait;
  stq_pkg::stq_word_t chk0_data;
  logic               chk1_valid;
  logic               chk1_hit;
  logic               chk1_wait;
  stq_pkg::stq_word_t chk1_data;
  logic               mem_wr_valid;
  stq_pkg::stq_addr_t mem_wr_addr;
  stq_pkg::stq_word_t mem_wr_data;

  // reference model of the queue, updated on the rising edge.
  stq_pkg::stq_vec_t  m_valid;
  stq_pkg::stq_vec_t  m_aw;  // address written.
  stq_pkg::stq_vec_t  m_dw;  // data written.
  stq_pkg::stq_addr_t m_addr [`STQ_ENTRIES];
  stq_pkg::stq_word_t m_data [`STQ_ENTRIES];
  stq_pkg::stq_idx_t  m_head;
  stq_pkg::stq_idx_t  m_tail;
  int                 m_count;
  int                 m_pending;
  logic               m_pop;
  logic [1:0][34:0]   exp0;  // {valid, hit, wait, data} for each pipe stage.
  logic [1:0][34:0]   exp1;
  logic [64:0]        exp_wr;  // {valid, addr, data} of the predicted memory write.
  int                 drained;
  integer             seed;
  stq_pkg::stq_addr_t base [4];
  logic [31:0]        r;

  stq_top stq_top_inst (.*);

  always #20 clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Verification failed");
    $fatal(1, "stopped on a timeout");
  endtask

  // the older stores run from age-1 back to the head; the first match is the youngest.
  function automatic logic [34:0] expect_check(input stq_pkg::stq_addr_t a,
                                               input stq_pkg::stq_idx_t age);
    stq_pkg::stq_idx_t idx;
    int                older;
    older = int'(stq_pkg::stq_idx_t'(age - m_head));
    for (int k = 1; k <= older; k++) begin
      idx = age - stq_pkg::stq_idx_t'(k);
      if (m_valid[idx] && m_aw[idx] && m_addr[idx] == a) begin
        return m_dw[idx] ? {3'b110, m_data[idx]} : {3'b101, 32'h0};
      end
    end
    return {3'b100, 32'h0};
  endfunction

  always @(posedge clk) begin
    if (!arst_n) begin
      m_valid   = '0;
      m_aw      = '0;
      m_dw      = '0;
      m_head    = '0;
      m_tail    = '0;
      m_count   = 0;
      m_pending = 0;
      exp0      = '0;
      exp1      = '0;
      exp_wr    = '0;
      drained   = 0;
    end else begin
      if (mem_wr_valid) begin
        drained++;
      end
      // checks see the state before this cycle's writes.
      exp0[1] = exp0[0];
      exp1[1] = exp1[0];
      exp0[0] = chk0_en ? expect_check(chk0_addr, chk0_age) : '0;
      exp1[0] = chk1_en ? expect_check(chk1_addr, chk1_age) : '0;
      m_pop   = m_pending > 0 && m_valid[m_head] && m_aw[m_head] && m_dw[m_head];
      exp_wr  = {m_pop, m_addr[m_head], m_data[m_head]};
      if (wrt0_en) begin
        m_addr[wrt0_idx] = wrt0_addr;
        m_aw[wrt0_idx]   = 1'b1;
      end
      if (wrt1_en) begin
        m_data[wrt1_idx] = wrt1_data;
        m_dw[wrt1_idx]   = 1'b1;
      end
      if (alloc && m_count < `STQ_ENTRIES) begin
        m_valid[m_tail] = 1'b1;
        m_tail++;
        m_count++;
      end
      if (m_pop) begin
        m_valid[m_head] = 1'b0;
        m_aw[m_head]    = 1'b0;
        m_dw[m_head]    = 1'b0;
        m_head++;
        m_count--;
        m_pending--;
      end
      if (commit) begin
        m_pending++;
      end
    end
  end

  a_ring_state: assert property (@(negedge clk) disable iff (!arst_n)
    alloc_idx == m_tail && full == (m_count == `STQ_ENTRIES) && empty == (m_count == 0)
  ) else report_mismatch("alloc_idx, full or empty differ from the model");

  a_chk0_result: assert property (@(negedge clk) disable iff (!arst_n)
    {chk0_valid, chk0_hit, chk0_wait} == exp0[1][34:32] &&
    (!exp0[1][33] || chk0_data == exp0[1][31:0])
  ) else report_mismatch("load check port 0 result differs from the model");

  a_chk1_result: assert property (@(negedge clk) disable iff (!arst_n)
    {chk1_valid, chk1_hit, chk1_wait} == exp1[1][34:32] &&
    (!exp1[1][33] || chk1_data == exp1[1][31:0])
  ) else report_mismatch("load check port 1 result differs from the model");

  a_drain_write: assert property (@(negedge clk) disable iff (!arst_n)
    mem_wr_valid == exp_wr[64] && (!exp_wr[64] || {mem_wr_addr, mem_wr_data} == exp_wr[63:0])
  ) else report_mismatch("memory write differs from the oldest committed store");

  // holds the driven inputs for one clock, then returns the strobes to idle.
  task automatic step();
    @(negedge clk);
    alloc   = 1'b0;
    wrt0_en = 1'b0;
    wrt1_en = 1'b0;
    chk0_en = 1'b0;
    chk1_en = 1'b0;
    commit  = 1'b0;
  endtask

  task automatic check_loads(input stq_pkg::stq_addr_t a0, input stq_pkg::stq_idx_t age0,
                             input stq_pkg::stq_addr_t a1, input stq_pkg::stq_idx_t age1);
    chk0_en   = 1'b1;
    chk0_addr = a0;
    chk0_age  = age0;
    chk1_en   = 1'b1;
    chk1_addr = a1;
    chk1_age  = age1;
    step();
  endtask

  task automatic wait_drained(input int target);
    int n;
    n = 0;
    while (drained < target && n < 500) begin
      @(negedge clk);
      n++;
    end
    if (drained < target) begin
      abort_on_timeout("the store queue to drain");
    end
  endtask

  initial begin
    seed      = 32'hca84_677e;
    clk       = 1'b0;
    arst_n    = 1'b0;
    alloc     = 1'b0;
    wrt0_en   = 1'b0;
    wrt0_idx  = '0;
    wrt0_addr = '0;
    wrt1_en   = 1'b0;
    wrt1_idx  = '0;
    wrt1_data = '0;
    chk0_en   = 1'b0;
    chk0_addr = '0;
    chk0_age  = '0;
    chk1_en   = 1'b0;
    chk1_addr = '0;
    chk1_age  = '0;
    commit    = 1'b0;
    for (int i = 0; i < 4; i++) begin
      base[i] = $random(seed);
    end
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    assert (empty && !full && alloc_idx == '0 && !chk0_valid && !chk1_valid &&
            !chk0_hit && !chk0_wait && !chk1_hit && !chk1_wait && !mem_wr_valid)
      else report_mismatch("outputs are not idle after reset");

    for (int i = 0; i < `STQ_ENTRIES; i++) begin
      assert (alloc_idx == stq_pkg::stq_idx_t'(i) && !full)
        else report_mismatch("alloc_idx does not follow allocation order");
      alloc = 1'b1;
      step();
    end
    assert (full && !empty) else report_mismatch("full is low after 64 allocations");

    // every third entry gets a unique address, the rest share four.
    for (int i = 0; i < `STQ_ENTRIES; i++) begin
      wrt0_en   = (i != 3);  // entry 3 waits for its address.
      wrt0_idx  = stq_pkg::stq_idx_t'(i);
      wrt0_addr = (i % 3 == 2) ? $random(seed) : base[i % 4];
      wrt1_en   = (i != 0) && (i != 45);  // entries 0 and 45 wait for data.
      wrt1_idx  = stq_pkg::stq_idx_t'(i);
      wrt1_data = $random(seed);
      step();
    end

    check_loads(base[1], 6'd40, base[2], 6'd30);  // several older matches.
    check_loads(base[3], 6'd3, $random(seed), 6'd63);  // only younger or no match.
    check_loads(base[1], 6'd46, base[0], 6'd1);  // youngest match has no data.
    wrt1_en   = 1'b1;
    wrt1_idx  = 6'd45;
    wrt1_data = $random(seed);
    step();
    check_loads(base[1], 6'd46, base[0], 6'd1);

    // data writes never share a cycle with a check.
    for (int n = 0; n < 80; n++) begin
      r = $random(seed);
      if (r[0]) begin
        chk0_en   = 1'b1;
        chk0_addr = base[r[2:1]];
        chk0_age  = r[13:8];
        chk1_en   = r[3];
        chk1_addr = r[4] ? base[r[6:5]] : $random(seed);
        chk1_age  = r[21:16];
      end else begin
        wrt1_en   = 1'b1;
        wrt1_idx  = stq_pkg::stq_idx_t'(1 + r[21:16] % 63);
        wrt1_data = $random(seed);
      end
      wrt0_en   = r[7];
      wrt0_idx  = stq_pkg::stq_idx_t'(4 + r[29:24] % 60);  // entry 3 stays without one.
      wrt0_addr = base[r[31:30]];
      step();
    end

    repeat (3) begin
      commit = 1'b1;
      step();
    end
    repeat (10) step();
    assert (full && drained == 0)
      else report_mismatch("a store drained before its data was written");
    wrt1_en   = 1'b1;
    wrt1_idx  = '0;
    wrt1_data = $random(seed);
    step();
    wait_drained(3);
    // the new head has its data but still no address.
    commit = 1'b1;
    step();
    repeat (10) step();
    assert (drained == 3)
      else report_mismatch("a store drained before its address was written");
    wrt0_en   = 1'b1;
    wrt0_idx  = 6'd3;
    wrt0_addr = $random(seed);
    step();
    for (int i = 4; i < `STQ_ENTRIES; i++) begin
      commit = 1'b1;
      step();
    end
    wait_drained(`STQ_ENTRIES);
    if (empty && !full && drained == `STQ_ENTRIES) begin
      $display("Verification passed");
      $finish;
    end else begin
      report_mismatch("queue is not empty after every store drained");
    end
  end

endmodule

/* hw/stq_top.sv */
`timescale 1ns/100ps

module stq_top (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               alloc,
  output stq_pkg::stq_idx_t  alloc_idx,
  output logic               full,
  output logic               empty,
  input  logic               wrt0_en,
  input  stq_pkg::stq_idx_t  wrt0_idx,
  input  stq_pkg::stq_addr_t wrt0_addr,
  input  logic               wrt1_en,
  input  stq_pkg::stq_idx_t  wrt1_idx,
  input  stq_pkg::stq_word_t wrt1_data,
  input  logic               chk0_en,
  input  stq_pkg::stq_addr_t chk0_addr,
  input  stq_pkg::stq_idx_t  chk0_age,
  input  logic               chk1_en,
  input  stq_pkg::stq_addr_t chk1_addr,
  input  stq_pkg::stq_idx_t  chk1_age,
  output logic               chk0_valid,
  output logic               chk0_hit,
  output logic               chk0_wait,
  output stq_pkg::stq_word_t chk0_data,
  output logic               chk1_valid,
  output logic               chk1_hit,
  output logic               chk1_wait,
  output stq_pkg::stq_word_t chk1_data,
  input  logic               commit,
  output logic               mem_wr_valid,
  output stq_pkg::stq_addr_t mem_wr_addr,
  output stq_pkg::stq_word_t mem_wr_data
);

  stq_pkg::stq_vec_t  entry_valid;
  stq_pkg::stq_vec_t  addr_valid;
  stq_pkg::stq_vec_t  data_valid;
  stq_pkg::stq_idx_t  head;
  stq_pkg::stq_vec_t  chk0_sel;
  stq_pkg::stq_vec_t  chk1_sel;
  logic               chk0_found;
  logic               chk1_found;
  logic               chk0_strobe;
  logic               chk1_strobe;
  stq_pkg::stq_addr_t head_addr;
  stq_pkg::stq_word_t head_data;
  logic               pop;

  stq_ring stq_ring_inst (
    .clk, .arst_n, .alloc, .pop, .alloc_idx, .head, .entry_valid, .full, .empty
  );

  // checks are compared here in the cycle after they issue.
  stq_addr_cam stq_addr_cam_inst (
    .clk, .arst_n, .entry_valid, .head,
    .wrt0_en, .wrt0_idx, .wrt0_addr,
    .chk0_en, .chk0_addr, .chk0_age,
    .chk1_en, .chk1_addr, .chk1_age,
    .chk0_sel, .chk1_sel, .chk0_found, .chk1_found,
    .chk0_strobe, .chk1_strobe, .addr_valid, .head_addr
  );

  stq_data_array stq_data_array_inst (
    .clk, .arst_n, .entry_valid,
    .wrt1_en, .wrt1_idx, .wrt1_data,
    .chk0_sel, .chk1_sel, .chk0_found, .chk1_found,
    .chk0_strobe, .chk1_strobe,
    .chk0_valid, .chk0_hit, .chk0_wait, .chk0_data,
    .chk1_valid, .chk1_hit, .chk1_wait, .chk1_data,
    .data_valid, .head, .head_data
  );

  stq_drain stq_drain_inst (
    .clk, .arst_n, .commit, .head, .entry_valid, .addr_valid, .data_valid,
    .head_addr, .head_data, .pop, .mem_wr_valid, .mem_wr_addr, .mem_wr_data
  );

endmodule

/* hw/stq_drain.sv */
`timescale 1ns/100ps

`include "stq_consts.svh"

module stq_drain (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               commit,
  input  stq_pkg::stq_idx_t  head,
  input  stq_pkg::stq_vec_t  entry_valid,
  input  stq_pkg::stq_vec_t  addr_valid,
  input  stq_pkg::stq_vec_t  data_valid,
  input  stq_pkg::stq_addr_t head_addr,
  input  stq_pkg::stq_word_t head_data,
  output logic               pop,
  output logic               mem_wr_valid,
  output stq_pkg::stq_addr_t mem_wr_addr,
  output stq_pkg::stq_word_t mem_wr_data
);

  stq_pkg::stq_count_t pending;  // retired stores not yet written out.
  logic                head_ready;

  // the head can go once both halves of the store have arrived.
  assign head_ready = entry_valid[head] & addr_valid[head] & data_valid[head];
  assign pop        = (pending != '0) & head_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending      <= '0;
      mem_wr_valid <= 1'b0;
    end else begin
      pending      <= pending + stq_pkg::stq_count_t'(commit) - stq_pkg::stq_count_t'(pop);
      mem_wr_valid <= pop;
    end
  end

  // address and data are captured on the edge that advances the head.
  always_ff @(posedge clk) begin
    if (pop) begin
      mem_wr_addr <= head_addr;
      mem_wr_data <= head_data;
    end
  end

  // commits only name stores that are still held in the queue.
  a_pending_bounded: assert property (
    @(posedge clk) disable iff (!arst_n)
      int'(pending) <= $countones(entry_valid)
  ) else $error("more pending commits than allocated stores.");

endmodule

/* hw/stq_data_array.sv */
`timescale 1ns/100ps

`include "stq_consts.svh"

module stq_data_array (
  input  logic               clk,
  input  logic               arst_n,
  input  stq_pkg::stq_vec_t  entry_valid,
  input  logic               wrt1_en,
  input  stq_pkg::stq_idx_t  wrt1_idx,
  input  stq_pkg::stq_word_t wrt1_data,
  input  stq_pkg::stq_vec_t  chk0_sel,
  input  stq_pkg::stq_vec_t  chk1_sel,
  input  logic               chk0_found,
  input  logic               chk1_found,
  input  logic               chk0_strobe,
  input  logic               chk1_strobe,
  output logic               chk0_valid,
  output logic               chk0_hit,
  output logic               chk0_wait,
  output stq_pkg::stq_word_t chk0_data,
  output logic               chk1_valid,
  output logic               chk1_hit,
  output logic               chk1_wait,
  output stq_pkg::stq_word_t chk1_data,
  output stq_pkg::stq_vec_t  data_valid,
  input  stq_pkg::stq_idx_t  head,
  output stq_pkg::stq_word_t head_data
);

  stq_pkg::stq_word_t data_mem [`STQ_ENTRIES];
  stq_pkg::stq_vec_t  wr_mask;
  stq_pkg::stq_word_t rd0;
  stq_pkg::stq_word_t rd1;
  logic               dv0;
  logic               dv1;

  always_comb begin
    wr_mask           = '0;
    wr_mask[wrt1_idx] = wrt1_en;
  end

  // and-or mux; the selects are one-hot or zero, so at most one word passes.
  always_comb begin
    rd0 = '0;
    rd1 = '0;
    for (int i = 0; i < `STQ_ENTRIES; i++) begin
      rd0 = rd0 | (data_mem[i] & {`STQ_DATA_W{chk0_sel[i]}});
      rd1 = rd1 | (data_mem[i] & {`STQ_DATA_W{chk1_sel[i]}});
    end
  end

  assign dv0 = |(chk0_sel & data_valid);  // selected store has its data.
  assign dv1 = |(chk1_sel & data_valid);

  always_ff @(posedge clk) begin
    if (wrt1_en) begin
      data_mem[wrt1_idx] <= wrt1_data;
    end
    if (chk0_strobe) begin
      chk0_data <= rd0;
    end
    if (chk1_strobe) begin
      chk1_data <= rd1;
    end
  end

  assign head_data = data_mem[head];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_valid <= '0;
      chk0_valid <= 1'b0;
      chk0_hit   <= 1'b0;
      chk0_wait  <= 1'b0;
      chk1_valid <= 1'b0;
      chk1_hit   <= 1'b0;
      chk1_wait  <= 1'b0;
    end else begin
      data_valid <= (data_valid & entry_valid) | wr_mask;
      chk0_valid <= chk0_strobe;
      chk0_hit   <= chk0_strobe & chk0_found & dv0;
      chk0_wait  <= chk0_strobe & chk0_found & ~dv0;  // the load must retry.
      chk1_valid <= chk1_strobe;
      chk1_hit   <= chk1_strobe & chk1_found & dv1;
      chk1_wait  <= chk1_strobe & chk1_found & ~dv1;
    end
  end

  // data may only land in an entry that the ring has allocated.
  a_wrt1_valid_entry: assert property (
    @(posedge clk) disable iff (!arst_n) wrt1_en |-> entry_valid[wrt1_idx]
  ) else $error("data write to an unallocated entry.");

endmodule

/* hw/stq_addr_cam.sv */
`timescale 1ns/100ps

`include "stq_consts.svh"

module stq_addr_cam (
  input  logic               clk,
  input  logic               arst_n,
  input  stq_pkg::stq_vec_t  entry_valid,
  input  stq_pkg::stq_idx_t  head,
  input  logic               wrt0_en,
  input  stq_pkg::stq_idx_t  wrt0_idx,
  input  stq_pkg::stq_addr_t wrt0_addr,
  input  logic               chk0_en,
  input  stq_pkg::stq_addr_t chk0_addr,
  input  stq_pkg::stq_idx_t  chk0_age,
  input  logic               chk1_en,
  input  stq_pkg::stq_addr_t chk1_addr,
  input  stq_pkg::stq_idx_t  chk1_age,
  output stq_pkg::stq_vec_t  chk0_sel,
  output stq_pkg::stq_vec_t  chk1_sel,
  output logic               chk0_found,
  output logic               chk1_found,
  output logic               chk0_strobe,
  output logic               chk1_strobe,
  output stq_pkg::stq_vec_t  addr_valid,
  output stq_pkg::stq_addr_t head_addr
);

  stq_pkg::stq_addr_t addr_mem [`STQ_ENTRIES];
  stq_pkg::stq_vec_t  wr_mask;
  stq_pkg::stq_vec_t  eq0;
  stq_pkg::stq_vec_t  eq1;
  stq_pkg::stq_vec_t  sel0_d;
  stq_pkg::stq_vec_t  sel1_d;

  // walks from the head towards the age, so the last candidate seen is the
  // youngest store that is still older than the load.
  function automatic stq_pkg::stq_vec_t pick_youngest(
    input stq_pkg::stq_vec_t cand,
    input stq_pkg::stq_idx_t head_i,
    input stq_pkg::stq_idx_t age
  );
    stq_pkg::stq_idx_t rel_age;
    stq_pkg::stq_idx_t idx;
    stq_pkg::stq_vec_t sel;
    rel_age = age - head_i;  // number of stores older than the load.
    sel     = '0;
    for (int k = 0; k < `STQ_ENTRIES; k++) begin
      idx = head_i + stq_pkg::stq_idx_t'(k);
      if (cand[idx] && (stq_pkg::stq_idx_t'(k) < rel_age)) begin
        sel      = '0;
        sel[idx] = 1'b1;
      end
    end
    return sel;
  endfunction

  always_comb begin
    wr_mask           = '0;
    wr_mask[wrt0_idx] = wrt0_en;
  end

  // full word compare against every entry, then keep the live ones.
  always_comb begin
    for (int i = 0; i < `STQ_ENTRIES; i++) begin
      eq0[i] = (addr_mem[i] == chk0_addr);
      eq1[i] = (addr_mem[i] == chk1_addr);
    end
    sel0_d = pick_youngest(eq0 & entry_valid & addr_valid, head, chk0_age);
    sel1_d = pick_youngest(eq1 & entry_valid & addr_valid, head, chk1_age);
  end

  always_ff @(posedge clk) begin
    if (wrt0_en) begin
      addr_mem[wrt0_idx] <= wrt0_addr;
    end
  end

  assign head_addr = addr_mem[head];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr_valid  <= '0;
      chk0_sel    <= '0;
      chk1_sel    <= '0;
      chk0_found  <= 1'b0;
      chk1_found  <= 1'b0;
      chk0_strobe <= 1'b0;
      chk1_strobe <= 1'b0;
    end else begin
      // a released entry loses its address one cycle after its valid bit.
      addr_valid  <= (addr_valid & entry_valid) | wr_mask;
      chk0_sel    <= chk0_en ? sel0_d : '0;
      chk1_sel    <= chk1_en ? sel1_d : '0;
      chk0_found  <= chk0_en & (|sel0_d);
      chk1_found  <= chk1_en & (|sel1_d);
      chk0_strobe <= chk0_en;
      chk1_strobe <= chk1_en;
    end
  end

  // the data stage does an and-or read, so two bits set would merge two words.
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (!arst_n)
      $onehot0(chk0_sel) && $onehot0(chk1_sel)
  ) else $error("check select is not one-hot.");

  // an address may only land in an entry that the ring has allocated.
  a_wrt0_valid_entry: assert property (
    @(posedge clk) disable iff (!arst_n) wrt0_en |-> entry_valid[wrt0_idx]
  ) else $error("address write to an unallocated entry.");

endmodule

/* hw/stq_ring.sv */
`timescale 1ns/100ps

`include "stq_consts.svh"

module stq_ring (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              alloc,
  input  logic              pop,
  output stq_pkg::stq_idx_t alloc_idx,
  output stq_pkg::stq_idx_t head,
  output stq_pkg::stq_vec_t entry_valid,
  output logic              full,
  output logic              empty
);

  stq_pkg::stq_idx_t   tail;
  stq_pkg::stq_count_t count;
  logic                alloc_ok;
  stq_pkg::stq_vec_t   set_mask;
  stq_pkg::stq_vec_t   clr_mask;

  assign alloc_idx = tail;  // the new entry is the current tail.
  assign full      = (count == stq_pkg::stq_count_t'(`STQ_ENTRIES));
  assign empty     = (count == '0);

  // a request while full is dropped here.
  assign alloc_ok = alloc & ~full;

  always_comb begin
    set_mask       = '0;
    clr_mask       = '0;
    set_mask[tail] = alloc_ok;
    clr_mask[head] = pop;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      entry_valid <= '0;
    end else begin
      if (alloc_ok) begin
        tail <= tail + 1'b1;  // wraps at the index width.
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      count       <= count + stq_pkg::stq_count_t'(alloc_ok) - stq_pkg::stq_count_t'(pop);
      entry_valid <= (entry_valid & ~clr_mask) | set_mask;
    end
  end

  // dispatch must stall on full instead of relying on the drop above.
  a_no_alloc_when_full: assert property (
    @(posedge clk) disable iff (!arst_n) alloc |-> !full
  ) else $error("store queue allocation while full.");

  // the drain stage only pops a valid head, so an empty queue never pops.
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!arst_n) pop |-> !empty && entry_valid[head]
  ) else $error("store queue pop while empty.");

  // the valid bits and the count describe the same occupancy.
  a_count_matches: assert property (
    @(posedge clk) disable iff (!arst_n)
      $countones(entry_valid) == int'(count)
  ) else $error("store queue count out of step with valid bits.");

endmodule

/* hw/stq_pkg.sv */
`include "stq_consts.svh"

package stq_pkg;

  // entry index, also used for the head, the tail and a load's age.
  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;

  // occupancy needs one more bit so a full queue can be told from an empty one.
  typedef logic [`STQ_IDX_W:0] stq_count_t;

  // one bit per entry, used for valid bits and one-hot selects.
  typedef logic [`STQ_ENTRIES-1:0] stq_vec_t;

  typedef logic [`STQ_ADDR_W-1:0] stq_addr_t;  // word address.

  typedef logic [`STQ_DATA_W-1:0] stq_word_t;  // store data.

endpackage

/* hw/stq_consts.svh */
`ifndef STQ_CONSTS_SVH
`define STQ_CONSTS_SVH

// number of store queue entries, kept in program order.
`define STQ_ENTRIES 64

// width of an entry index; the ring pointers wrap at this width.
`define STQ_IDX_W 6

// loads and stores compare as whole words of this width.
`define STQ_ADDR_W 32

// width of one store's data word.
`define STQ_DATA_W 32

`endif
